// ==== Makefile ====
# Verilator flow for the audio lab

TB_TOP := tb_board_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module board_top \
		hdl/audio_lab_pkg.sv hdl/pmod_mic3_receiver.sv hdl/note_selector.sv \
		hdl/tone_voice.sv hdl/voice_mixer.sv hdl/i2s_transmitter.sv hdl/board_top.sv

obj_dir/V$(TB_TOP): project.f
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB_TOP) -f project.f

sim: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Result: FAILED" sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/audio_lab_pkg.sv ====
// Audio lab shared definitions

`default_nettype none

package audio_lab_pkg;

    //------------------------------------------------------------------------

    localparam int max_keys = 8;              // Upper bound for the key count

    // One signed audio sample, as mixed and sent to the codec
    typedef logic signed [15:0] sample_t;

    // Control word from the note selector to one voice
    typedef struct packed {
        logic        enable;                  // Key is held
        logic [19:0] half_period;             // In clk cycles
    } voice_ctrl_t;

    //------------------------------------------------------------------------

    localparam sample_t     voice_amplitude = 16'sh2000;  // Peak of one voice
    localparam logic [11:0] mic_offset      = 12'h800;    // ADC mid-scale

    // C5 up to C6, one entry per key
    localparam int unsigned note_hz [max_keys] = '{
        523,                                  // C5
        587,                                  // D5
        659,                                  // E5
        698,                                  // F5
        784,                                  // G5
        880,                                  // A5
        988,                                  // B5
        1047                                  // C6
    };

endpackage

`default_nettype wire

// ==== hdl/board_top.sv ====
// Audio lab board top

`default_nettype none

module board_top #(
    parameter  int clk_mhz = 50,
    parameter  int w_key   = 4,
    localparam int w_led   = 4
) (
    input  wire                 clk,
    input  wire                 arst_n,

    input  wire  [w_key - 1:0]  key,          // Pressed is low
    output logic [w_led - 1:0]  led,          // Lit is low

    output logic                mic_cs,
    output logic                mic_sck,
    input  wire                 mic_sdo,

    output logic                i2s_mclk,
    output logic                i2s_bclk,
    output logic                i2s_lrclk,
    output logic                i2s_sdata
);

    import audio_lab_pkg::*;

    //------------------------------------------------------------------------

    logic [w_key - 1:0] lab_key;
    logic [w_led - 1:0] lab_led;

    logic [11:0]        mic_code;
    logic               sample_valid;
    logic signed [11:0] mic_delta;
    logic [11:0]        mic_level;
    sample_t            mic_sample;

    voice_ctrl_t        voice_ctrl [w_key];
    sample_t            voices     [w_key];
    sample_t            mix_sample;

    logic               frame_start;
    logic               mic_fresh;            // New code since last refresh

    assign lab_key = ~key;
    assign led     = ~lab_led;

    //------------------------------------------------------------------------
    // Microphone

    pmod_mic3_receiver i_microphone (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .cs           ( mic_cs       ),
        .sck          ( mic_sck      ),
        .sdo          ( mic_sdo      ),
        .mic_code     ( mic_code     ),
        .sample_valid ( sample_valid )
    );

    assign mic_delta  = mic_code - mic_offset;     // Centre on zero
    assign mic_sample = {mic_delta, 4'b0000};      // Scale to 16 bits
    assign mic_level  = mic_delta[11] ? 12'(-mic_delta) : mic_delta;

    //------------------------------------------------------------------------
    // Voices

    note_selector #(
        .clk_mhz ( clk_mhz ),
        .w_key   ( w_key   )
    ) i_note_selector (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .keys       ( lab_key    ),
        .voice_ctrl ( voice_ctrl )
    );

    for (genvar i = 0; i < w_key; i++) begin : g_voice
        tone_voice i_voice (
            .clk    ( clk           ),
            .arst_n ( arst_n        ),
            .ctrl   ( voice_ctrl[i] ),
            .sample ( voices[i]     )
        );
    end

    voice_mixer #(
        .w_key ( w_key )
    ) i_mixer (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .voices     ( voices     ),
        .mic_sample ( mic_sample ),
        .mix_sample ( mix_sample )
    );

    //------------------------------------------------------------------------
    // Audio out

    i2s_transmitter i_audio_out (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .sample      ( mix_sample  ),
        .mclk        ( i2s_mclk    ),
        .bclk        ( i2s_bclk    ),
        .lrclk       ( i2s_lrclk   ),
        .sdata       ( i2s_sdata   ),
        .frame_start ( frame_start )
    );

    //------------------------------------------------------------------------
    // Loudness bar, refreshed once per frame after a new conversion

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lab_led   <= '0;
            mic_fresh <= 1'b0;
        end else if (frame_start && mic_fresh) begin
            for (int n = 0; n < w_led; n++)
                lab_led[n] <= (mic_level >= 12'(256 * (n + 1)));
            mic_fresh <= sample_valid;
        end else if (sample_valid) begin
            mic_fresh <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/i2s_transmitter.sv ====
// I2S audio transmitter

`default_nettype none

module i2s_transmitter (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire audio_lab_pkg::sample_t sample,

    output logic                        mclk,
    output logic                        bclk,
    output logic                        lrclk,
    output logic                        sdata,
    output logic                        frame_start
);

    import audio_lab_pkg::*;

    //------------------------------------------------------------------------

    logic [8:0] cnt;                          // One frame is 512 clk cycles
    sample_t    held;                         // Word sent in both slots
    logic [3:0] bit_sel;

    // Standard I2S delay: bclk 0 of a slot still carries the previous LSB,
    // the MSB follows one bclk after the lrclk edge
    assign bit_sel = 4'd0 - cnt[7:4];

    //------------------------------------------------------------------------
    // Clocks

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt         <= '0;
            mclk        <= 1'b0;
            bclk        <= 1'b0;
            lrclk       <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            cnt         <= cnt + 1'b1;
            mclk        <= cnt[1];            // clk / 4
            bclk        <= cnt[3];            // clk / 16
            lrclk       <= cnt[8];            // Left slot low, right high
            frame_start <= (cnt == '0);
        end
    end

    //------------------------------------------------------------------------
    // Serial data

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held  <= '0;
            sdata <= 1'b0;
        end else begin
            if (cnt[3:0] == 4'd0)
                sdata <= held[bit_sel];       // Moves with the bclk fall

            if (cnt == '0)
                held <= sample;               // Old held still feeds this bit
        end
    end

    //------------------------------------------------------------------------

    a_lrclk_on_bclk_fall : assert property (
        @(posedge clk) disable iff (!arst_n)
        $changed(lrclk) |-> $fell(bclk)
    );

endmodule

`default_nettype wire

// ==== hdl/note_selector.sv ====
// Key to note selector

`default_nettype none

module note_selector #(
    parameter int clk_mhz = 50,
    parameter int w_key   = 4
) (
    input  wire                        clk,
    input  wire                        arst_n,

    input  wire  [w_key - 1:0]         keys,
    output audio_lab_pkg::voice_ctrl_t voice_ctrl [w_key]
);

    import audio_lab_pkg::*;

    //------------------------------------------------------------------------

    logic [w_key - 1:0] keys_meta;
    logic [w_key - 1:0] keys_sync;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            keys_meta <= '0;
            keys_sync <= '0;
        end else begin
            keys_meta <= keys;                // Buttons are asynchronous
            keys_sync <= keys_meta;
        end
    end

    //------------------------------------------------------------------------

    for (genvar i = 0; i < w_key; i++) begin : g_note

        // Half of one note period, fixed at elaboration
        localparam logic [19:0] half_period =
            20'(clk_mhz * 1000000 / (2 * note_hz[i]));

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n)
                voice_ctrl[i] <= '0;
            else
                voice_ctrl[i] <= '{enable: keys_sync[i], half_period: half_period};
        end
    end

    //------------------------------------------------------------------------

    a_key_count : assert property (@(posedge clk) w_key <= max_keys);

endmodule

`default_nettype wire

// ==== hdl/pmod_mic3_receiver.sv ====
// PMOD MIC3 SPI receiver

`default_nettype none

module pmod_mic3_receiver (
    input  wire         clk,
    input  wire         arst_n,

    output logic        cs,
    output logic        sck,
    input  wire         sdo,

    output logic [11:0] mic_code,
    output logic        sample_valid
);

    import audio_lab_pkg::*;

    //------------------------------------------------------------------------

    logic [ 2:0] div;                         // Eight clk cycles per sck
    logic [ 4:0] phase;                       // 16 active plus 4 quiet periods
    logic [11:0] shift;
    logic        idle;

    assign idle = (phase >= 5'd16);

    //------------------------------------------------------------------------
    // Frame timing and SPI pins

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div   <= '0;
            phase <= 5'd16;                   // Start in the quiet part
            cs    <= 1'b1;
            sck   <= 1'b0;
        end else begin
            div <= div + 1'b1;

            if (div == 3'd7)
                phase <= (phase == 5'd19) ? 5'd0 : phase + 1'b1;

            cs  <= idle;
            sck <= div[2] & ~idle;            // High for the second half
        end
    end

    //------------------------------------------------------------------------
    // Data capture

    // sck goes high on the edge where div is 4, so sdo is taken there
    always_ff @(posedge clk) begin
        if (div == 3'd4 && !idle && phase >= 5'd4)
            shift <= {shift[10:0], sdo};      // Skip the four leading zeros
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mic_code     <= mic_offset;       // Silence until the first frame
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= idle & ~cs;       // Same edge that raises cs
            if (idle && !cs)
                mic_code <= shift;
        end
    end

    //------------------------------------------------------------------------

    a_sck_idle_low : assert property (
        @(posedge clk) disable iff (!arst_n) cs |-> !sck
    );

endmodule

`default_nettype wire

// ==== hdl/tone_voice.sv ====
// Square wave voice

`default_nettype none

module tone_voice (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire audio_lab_pkg::voice_ctrl_t ctrl,
    output audio_lab_pkg::sample_t      sample
);

    import audio_lab_pkg::*;

    //------------------------------------------------------------------------

    logic [19:0] count;                       // Cycles left in this half
    logic        polarity;                    // Set for the negative half

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count    <= '0;
            polarity <= 1'b0;
            sample   <= '0;
        end else if (!ctrl.enable) begin
            count    <= '0;                   // Next press starts a fresh wave
            polarity <= 1'b0;
            sample   <= '0;
        end else begin
            if (count == '0) begin
                count    <= ctrl.half_period - 1'b1;
                polarity <= ~polarity;
            end else begin
                count    <= count - 1'b1;
            end

            sample <= polarity ? -voice_amplitude : voice_amplitude;
        end
    end

    //------------------------------------------------------------------------

    // A zero period would reload with all ones and play a wrong note
    a_period_set : assert property (
        @(posedge clk) disable iff (!arst_n)
        ctrl.enable |-> ctrl.half_period != '0
    );

endmodule

`default_nettype wire

// ==== hdl/voice_mixer.sv ====
// Saturating voice mixer

`default_nettype none

module voice_mixer #(
    parameter int w_key = 4
) (
    input  wire                        clk,
    input  wire                        arst_n,

    input  wire audio_lab_pkg::sample_t voices [w_key],
    input  wire audio_lab_pkg::sample_t mic_sample,
    output audio_lab_pkg::sample_t     mix_sample
);

    import audio_lab_pkg::*;

    //------------------------------------------------------------------------

    // Room for w_key voices plus the microphone without overflow
    localparam int w_acc = 16 + $clog2(w_key + 1);

    typedef logic signed [w_acc - 1:0] acc_t;

    localparam sample_t sample_max = 16'sh7FFF;
    localparam sample_t sample_min = 16'sh8000;

    acc_t acc;

    //------------------------------------------------------------------------

    always_comb begin
        acc = acc_t'(mic_sample);
        for (int i = 0; i < w_key; i++)
            acc = acc + acc_t'(voices[i]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mix_sample <= '0;
        else if (acc > acc_t'(sample_max))
            mix_sample <= sample_max;         // Clip high
        else if (acc < acc_t'(sample_min))
            mix_sample <= sample_min;         // Clip low
        else
            mix_sample <= sample_t'(acc);
    end

    //------------------------------------------------------------------------

    a_mix_known : assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(mix_sample)
    );

endmodule

`default_nettype wire

// ==== project.f ====
hdl/audio_lab_pkg.sv
hdl/pmod_mic3_receiver.sv
hdl/note_selector.sv
hdl/tone_voice.sv
hdl/voice_mixer.sv
hdl/i2s_transmitter.sv
hdl/board_top.sv
verification/tb_board_top.sv

// ==== verification/audio_vectors.txt ====
// keys(pressed=1) mic_code mic_only_sample led_bar(lit=1)
// microphone only
0 800 0000 0
0 A00 2000 3
0 5F0 DF00 3
0 C00 4000 F
0 400 C000 F
0 8FF 0FF0 0
0 900 1000 1
// single notes at mid-scale
1 800 0000 0
4 800 0000 0
// all keys at full scale, both ends
F FFF 7FF0 F
F 000 8000 F
// release
0 A00 2000 3

// ==== verification/tb_board_top.sv ====
// Audio lab board testbench

`default_nettype none

module tb_board_top;

    //------------------------------------------------------------------------

    localparam int num_vectors  = 12;
    localparam int frame_cycles = 512;
    localparam int reset_cycles = 8;

    logic       clk;
    logic       arst_n;
    logic [3:0] key;
    logic [3:0] led;
    logic       mic_cs;
    logic       mic_sck;
    logic       mic_sdo;
    logic       i2s_mclk;
    logic       i2s_bclk;
    logic       i2s_lrclk;
    logic       i2s_sdata;

    // Four words per line: keys, mic code, mic-only sample, LED bar
    logic [15:0] vectors [4 * num_vectors];

    logic [11:0] mic_value;                   // Code the model converts

    // Slow clock so every note turns over within a few frames
    board_top #(
        .clk_mhz ( 1 ),
        .w_key   ( 4 )
    ) uut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .key       ( key       ),
        .led       ( led       ),
        .mic_cs    ( mic_cs    ),
        .mic_sck   ( mic_sck   ),
        .mic_sdo   ( mic_sdo   ),
        .i2s_mclk  ( i2s_mclk  ),
        .i2s_bclk  ( i2s_bclk  ),
        .i2s_lrclk ( i2s_lrclk ),
        .i2s_sdata ( i2s_sdata )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //------------------------------------------------------------------------
    // Microphone model, one bit per sck fall

    logic        prev_cs;
    logic        prev_sck;
    logic [15:0] mic_word;
    int          bit_idx;

    always @(posedge clk) begin
        prev_cs  <= mic_cs;
        prev_sck <= mic_sck;
        if (mic_cs) begin
            bit_idx <= 15;
            mic_sdo <= 1'b0;                  // First bit is a leading zero
        end else if (prev_cs) begin
            mic_word <= {4'b0000, mic_value};
        end else if (prev_sck && !mic_sck && bit_idx > 0) begin
            bit_idx <= bit_idx - 1;
            mic_sdo <= mic_word[bit_idx - 1];
        end
    end

    //------------------------------------------------------------------------
    // I2S decoder, LSB lands one bclk after the lrclk edge

    logic        prev_bclk;
    logic        last_lr;
    logic [15:0] shift_in;
    logic [15:0] left_word;
    logic [15:0] right_word;
    int          frame_count;

    always @(posedge clk) begin
        if (!arst_n) begin
            prev_bclk   <= 1'b0;
            last_lr     <= 1'b0;
            shift_in    <= '0;
            frame_count <= 0;
        end else begin
            prev_bclk <= i2s_bclk;
            if (i2s_bclk && !prev_bclk) begin
                shift_in <= {shift_in[14:0], i2s_sdata};
                last_lr  <= i2s_lrclk;
                if (i2s_lrclk != last_lr) begin
                    if (!last_lr) begin
                        left_word <= {shift_in[14:0], i2s_sdata};
                    end else begin
                        right_word  <= {shift_in[14:0], i2s_sdata};
                        frame_count <= frame_count + 1;
                    end
                end
            end
        end
    end

    //------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s 0x%0h 0x%0h", name, got, expected);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_frames(input int count);
        int start;
        start = frame_count;
        do
            @(posedge clk);
        while (frame_count < start + count);
    endtask

    // True if word is the clamped mix for some sign choice of held keys
    function automatic bit mix_is_legal(input logic [15:0] word,
                                        input logic [3:0] keys,
                                        input logic [15:0] mic);
        int sum;
        for (int signs = 0; signs < 16; signs++) begin
            sum = $signed(mic);
            for (int k = 0; k < 4; k++)
                if (keys[k])
                    sum += signs[k] ? -32'sh2000 : 32'sh2000;
            if (sum > 32767)
                sum = 32767;
            if (sum < -32768)
                sum = -32768;
            if (word == sum[15:0])
                return 1'b1;
        end
        return 1'b0;
    endfunction

    //------------------------------------------------------------------------
    // Watchdog

    initial begin
        repeat (num_vectors * 10 * frame_cycles + reset_cycles + frame_cycles)
            @(posedge clk);
        $display("Watchdog expired before all vectors were checked");
        $display("Result: FAILED");
        $fatal(1);
    end

    //------------------------------------------------------------------------
    // Stimulus and checks

    initial begin
        logic [3:0]  keys;
        logic [15:0] mic_expect;
        logic [3:0]  bar;
        bit          saw_pos;
        bit          saw_neg;

        $readmemh("verification/audio_vectors.txt", vectors);
        arst_n    = 1'b0;
        key       = 4'hF;                     // Nothing pressed
        mic_sdo   = 1'b0;
        mic_value = 12'h800;

        repeat (reset_cycles / 2) @(posedge clk);
        check_value("mic_cs", mic_cs, 1'b1);
        check_value("mic_sck", mic_sck, 1'b0);
        check_value("i2s_mclk", i2s_mclk, 1'b0);
        check_value("i2s_bclk", i2s_bclk, 1'b0);
        check_value("i2s_lrclk", i2s_lrclk, 1'b0);
        check_value("i2s_sdata", i2s_sdata, 1'b0);
        check_value("led", led, 4'hF);
        repeat (reset_cycles / 2) @(posedge clk);
        arst_n <= 1'b1;

        for (int v = 0; v < num_vectors; v++) begin
            keys       = vectors[4 * v][3:0];
            mic_expect = vectors[4 * v + 2];
            bar        = vectors[4 * v + 3][3:0];

            @(posedge clk);
            key       <= ~keys;
            mic_value <= vectors[4 * v + 1][11:0];

            wait_frames(4);                   // Let keys, mic and LEDs settle
            saw_pos = 1'b0;
            saw_neg = 1'b0;

            for (int f = 0; f < 4; f++) begin
                wait_frames(1);
                check_value("right_word", right_word, left_word);
                if (keys == 4'h0)
                    check_value("left_word", left_word, mic_expect);
                else
                    check_value("left_word_legal",
                                mix_is_legal(left_word, keys, mic_expect), 1'b1);
                if (left_word == 16'h2000)
                    saw_pos = 1'b1;
                if (left_word == 16'hE000)
                    saw_neg = 1'b1;
            end

            check_value("led", led, 4'(~bar));
            if ($countones(keys) == 1)
                check_value("voice_signs", {saw_pos, saw_neg}, 2'b11);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
